//--- project.f
source/rvIsaPkg.sv
source/exuCtrlPkg.sv
source/gprFile.sv
source/exuOperandSel.sv
source/exuAlu.sv
source/csrUnit.sv
source/dataMem.sv
source/exuCommit.sv
source/exuTop.sv
verif/exuTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module exuTb \
    -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/VexuTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

//--- verif/exuTb.sv
`timescale 1ns/1ps

module exuTb;
    import rvIsaPkg::*;
    import exuCtrlPkg::*;

    localparam int unsigned memAddrBits = 8;
    localparam int unsigned memBytes    = 8 << memAddrBits;
    localparam logic [63:0] trapVector  = 64'h100;

    typedef logic [memAddrBits+2:0] byteAddrT;

    typedef struct packed {
        wbT          wb;
        logic [63:0] result;
        logic [63:0] dnpc;
    } expectT;

    logic        clk;
    logic        rstN;
    exuCtrlT     ctrl;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [63:0] pc;
    logic [63:0] imm;
    wbT          wb;
    logic [63:0] dnpc;

    // shadow architectural state
    logic [63:0] regs [32];
    logic [7:0]  smem [memBytes];
    logic [63:0] scsr [5];

    int unsigned seq         = 0;
    int unsigned lastChecked = 0;
    int unsigned checks      = 0;
    int unsigned valueErrors = 0;
    int unsigned otherErrors = 0;

    exuTop #(
        .memAddrBits     (memAddrBits),
        .trapVectorReset (trapVector)
    ) exuTop_i (
        .clk  (clk),
        .rstN (rstN),
        .ctrl (ctrl),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .pc   (pc),
        .imm  (imm),
        .wb   (wb),
        .dnpc (dnpc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic exuCtrlT baseCtrl();
        exuCtrlT c;
        c           = '0;
        c.aluSrcA   = srcARs1;
        c.aluSrcB   = srcBRs2;
        c.aluOp     = aluAdd;
        c.branch    = brNone;
        c.memOp     = memLd;
        c.csrOp     = csrNone;
        c.wbSel     = wbAlu;
        return c;
    endfunction

    function automatic logic [63:0] rand64();
        return {$urandom(), $urandom()};
    endfunction

    function automatic logic [63:0] sext32(logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // slot order mstatus, mtvec, mscratch, mepc, mcause
    function automatic int csrSlot(logic [11:0] id);
        case (id)
            csrMstatus:  return 0;
            csrMtvec:    return 1;
            csrMscratch: return 2;
            csrMepc:     return 3;
            csrMcause:   return 4;
            default:     return -1;
        endcase
    endfunction

    function automatic logic [63:0] aluModel(aluOpE op, logic [63:0] a, logic [63:0] b);
        logic [63:0] prod;
        prod = a * b;
        case (op)
            aluAdd:  return a + b;
            aluSub:  return a - b;
            aluSll:  return a << b[5:0];
            aluSlt:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            aluSltu: return (a < b) ? 64'd1 : 64'd0;
            aluXor:  return a ^ b;
            aluSrl:  return a >> b[5:0];
            aluSra:  return $signed(a) >>> b[5:0];
            aluOr:   return a | b;
            aluAnd:  return a & b;
            aluMul:  return prod;
            aluAddw: return sext32(a[31:0] + b[31:0]);
            aluSubw: return sext32(a[31:0] - b[31:0]);
            aluSllw: return sext32(a[31:0] << b[4:0]);
            aluSrlw: return sext32(a[31:0] >> b[4:0]);
            aluSraw: return sext32($signed(a[31:0]) >>> b[4:0]);
            aluMulw: return sext32(prod[31:0]);
            default: return b;
        endcase
    endfunction

    // gather little-endian bytes and extend by shifting up and back down
    function automatic logic [63:0] loadModel(logic [63:0] addr, memOpE op);
        logic [63:0] raw;
        int          nBytes;
        int          sh;
        raw    = 64'd0;
        nBytes = 1 << op[1:0];
        for (int i = 0; i < nBytes; i++) begin
            raw[8*i +: 8] = smem[byteAddrT'(addr) + byteAddrT'(i)];
        end
        sh  = 64 - 8 * nBytes;
        raw = raw << sh;
        if (op[2]) begin
            return raw >> sh;
        end
        return $signed(raw) >>> sh;
    endfunction

    function automatic expectT predict();
        expectT      e;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] csrOld;
        logic [63:0] base;
        logic [63:0] next;
        logic        taken;
        int          slot;
        a = (ctrl.aluSrcA == srcAPc) ? pc : regs[rs1];
        case (ctrl.aluSrcB)
            srcBImm:  b = imm;
            srcBFour: b = 64'd4;
            default:  b = regs[rs2];
        endcase
        e.result = aluModel(ctrl.aluOp, a, b);
        slot     = csrSlot(imm[11:0]);
        csrOld   = (slot < 0) ? 64'd0 : scsr[slot];
        case (ctrl.wbSel)
            wbLoad:  e.wb.data = ctrl.memRead ? loadModel(e.result, ctrl.memOp) : 64'd0;
            wbCsr:   e.wb.data = csrOld;
            default: e.wb.data = e.result;
        endcase
        e.wb.rd    = rd;
        e.wb.valid = ctrl.regWen && rstN && (rd != 5'd0);
        base  = pc;
        taken = 1'b0;
        case (ctrl.branch)
            brJal:  taken = 1'b1;
            brJalr: begin
                base  = regs[rs1];
                taken = 1'b1;
            end
            brBeq:   taken = (e.result == 64'd0);
            brBne:   taken = (e.result != 64'd0);
            brBlt:   taken = e.result[0];
            brBge:   taken = (e.result == 64'd0) || !e.result[0];
            default: taken = 1'b0;
        endcase
        next = base + (taken ? imm : 64'd4);
        if (ctrl.csrOp == csrEcall) begin
            next = scsr[1];
        end else if (ctrl.csrOp == csrMret) begin
            next = scsr[3];
        end
        next[0] = 1'b0;
        e.dnpc  = next;
        return e;
    endfunction

    // applies the effects of the instruction that ends at this edge
    task automatic commitShadow();
        expectT      e;
        logic [63:0] csrIn;
        logic [63:0] old;
        int          slot;
        e     = predict();
        slot  = csrSlot(imm[11:0]);
        csrIn = ctrl.csrSrcImm ? {59'd0, rs1} : regs[rs1];
        if (ctrl.memWrite) begin
            for (int i = 0; i < (1 << ctrl.memOp[1:0]); i++) begin
                smem[byteAddrT'(e.result) + byteAddrT'(i)] = regs[rs2][8*i +: 8];
            end
        end
        if (ctrl.csrOp == csrEcall) begin
            scsr[3] = pc;
            scsr[4] = 64'd11;
        end else if (slot >= 0) begin
            old = scsr[slot];
            case (ctrl.csrOp)
                csrWrite: scsr[slot] = csrIn;
                csrSet:   scsr[slot] = old | csrIn;
                csrClear: scsr[slot] = old & ~csrIn;
                default: ;
            endcase
        end
        if (e.wb.valid) begin
            regs[rd] = e.wb.data;
        end
    endtask

    task automatic issue(input exuCtrlT c, input logic [4:0] s1, input logic [4:0] s2,
                         input logic [4:0] d, input logic [63:0] immV);
        @(posedge clk);
        commitShadow();
        ctrl <= c;
        rs1  <= s1;
        rs2  <= s2;
        rd   <= d;
        imm  <= immV;
        pc   <= rand64() & ~64'h3;
        seq  <= seq + 1;
    endtask

    task automatic reportMismatch(string name, logic [63:0] exp, logic [63:0] act);
        $display("ERR %s exp %h act %h at %0t", name, exp, act, $time);
        valueErrors++;
    endtask

    always @(negedge clk) begin
        expectT e;
        if (!rstN) begin
            if (wb.valid !== 1'b0) begin
                reportMismatch("wb.valid", 64'd0, 64'(wb.valid));
            end
        end else begin
            e = predict();
            checks++;
            if (wb.valid !== e.wb.valid) begin
                reportMismatch("wb.valid", 64'(e.wb.valid), 64'(wb.valid));
            end
            if (wb.rd !== e.wb.rd) begin
                reportMismatch("wb.rd", 64'(e.wb.rd), 64'(wb.rd));
            end
            if (wb.data !== e.wb.data) begin
                reportMismatch("wb.data", e.wb.data, wb.data);
            end
            if (dnpc !== e.dnpc) begin
                reportMismatch("dnpc", e.dnpc, dnpc);
            end
            lastChecked = seq;
        end
    end

    function automatic logic [63:0] alignedOffset(logic [1:0] w);
        logic [63:0] off;
        off = 64'($urandom_range(7, 0));
        return (off >> w) << w;
    endfunction

    task automatic randomAluOps(int count);
        exuCtrlT c;
        for (int n = 0; n < count; n++) begin
            c        = baseCtrl();
            c.regWen = 1'b1;
            c.aluOp  = aluOpE'(5'($urandom_range(17, 0)));
            if ($urandom_range(1, 0) == 1) begin
                c.aluSrcB = srcBImm;
            end
            issue(c, 5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)),
                  5'($urandom_range(31, 0)), rand64());
        end
    endtask

    // one store and then a load of every kind in the same doubleword
    task automatic storeThenLoads(int count);
        exuCtrlT     c;
        logic [63:0] base;
        logic [1:0]  w;
        for (int n = 0; n < count; n++) begin
            base       = rand64() & ~64'h7;
            w          = 2'($urandom_range(3, 0));
            c          = baseCtrl();
            c.memWrite = 1'b1;
            c.memOp    = memOpE'({1'b0, w});
            c.aluSrcB  = srcBImm;
            issue(c, 5'd0, 5'($urandom_range(31, 1)), 5'd0, base + alignedOffset(w));
            for (int k = 0; k < 7; k++) begin
                c         = baseCtrl();
                c.regWen  = 1'b1;
                c.memRead = 1'b1;
                c.memOp   = memOpE'(3'(k));
                c.aluSrcB = srcBImm;
                c.wbSel   = wbLoad;
                issue(c, 5'd0, 5'd0, 5'($urandom_range(31, 1)),
                      base + alignedOffset(2'(k)));
            end
        end
    endtask

    task automatic branchesAndJumps(int count);
        exuCtrlT    c;
        logic [4:0] s1;
        logic [4:0] s2;
        for (int n = 0; n < count; n++) begin
            c  = baseCtrl();
            s1 = 5'($urandom_range(31, 0));
            // equal operands now and then
            s2 = ($urandom_range(3, 0) == 0) ? s1 : 5'($urandom_range(31, 0));
            case ($urandom_range(5, 0))
                0: begin
                    c.branch = brBeq;
                    c.aluOp  = aluSub;
                end
                1: begin
                    c.branch = brBne;
                    c.aluOp  = aluSub;
                end
                2: begin
                    c.branch = brBlt;
                    c.aluOp  = ($urandom_range(1, 0) == 1) ? aluSlt : aluSltu;
                end
                3: begin
                    c.branch = brBge;
                    c.aluOp  = ($urandom_range(1, 0) == 1) ? aluSlt : aluSltu;
                end
                default: begin
                    c.branch  = ($urandom_range(1, 0) == 1) ? brJal : brJalr;
                    c.regWen  = 1'b1;
                    c.aluSrcA = srcAPc;
                    c.aluSrcB = srcBFour;
                end
            endcase
            issue(c, s1, s2, 5'($urandom_range(31, 0)), rand64());
        end
    endtask

    task automatic csrAccesses(int count);
        exuCtrlT     c;
        logic [63:0] immV;
        int unsigned sel;
        logic [11:0] ids [5] = '{csrMstatus, csrMtvec, csrMscratch, csrMepc, csrMcause};
        for (int n = 0; n < count; n++) begin
            c           = baseCtrl();
            c.regWen    = 1'b1;
            c.wbSel     = wbCsr;
            c.csrSrcImm = 1'($urandom_range(1, 0));
            immV        = rand64();
            immV[11:0]  = ids[$urandom_range(4, 0)];
            sel         = $urandom_range(9, 0);
            if (sel == 0) begin
                // mhartid is not implemented and reads zero
                immV[11:0] = 12'hf14;
            end else if (sel == 1) begin
                c.csrOp  = csrEcall;
                c.regWen = 1'b0;
            end else if (sel == 2) begin
                c.csrOp  = csrMret;
                c.regWen = 1'b0;
            end else begin
                c.csrOp = csrOpE'(3'($urandom_range(3, 1)));
            end
            issue(c, 5'($urandom_range(31, 0)), 5'd0, 5'($urandom_range(31, 0)), immV);
        end
    endtask

    task automatic trapAndReturn();
        exuCtrlT c;
        c       = baseCtrl();
        c.csrOp = csrEcall;
        issue(c, 5'd0, 5'd0, 5'd0, rand64());
        // read back mepc and mcause through a set with zero
        c           = baseCtrl();
        c.regWen    = 1'b1;
        c.wbSel     = wbCsr;
        c.csrOp     = csrSet;
        c.csrSrcImm = 1'b1;
        issue(c, 5'd0, 5'd0, 5'd7, {52'd0, csrMepc});
        issue(c, 5'd0, 5'd0, 5'd8, {52'd0, csrMcause});
        c.csrOp     = csrWrite;
        c.csrSrcImm = 1'b0;
        issue(c, 5'd9, 5'd0, 5'd0, {52'd0, csrMepc});
        c       = baseCtrl();
        c.csrOp = csrMret;
        issue(c, 5'd0, 5'd0, 5'd0, 64'd0);
        // x0 destination
        c         = baseCtrl();
        c.regWen  = 1'b1;
        c.aluSrcB = srcBImm;
        c.aluOp   = aluPassB;
        issue(c, 5'd0, 5'd0, 5'd0, rand64());
    endtask

    initial begin
        exuCtrlT c;
        int      timeLeft;
        void'($urandom(32'hf8a4_07d8));
        for (int i = 0; i < 32; i++) begin
            regs[i] = 64'd0;
        end
        for (int i = 0; i < int'(memBytes); i++) begin
            smem[i] = 8'd0;
        end
        for (int i = 0; i < 5; i++) begin
            scsr[i] = 64'd0;
        end
        scsr[1] = trapVector;

        // a register write held during reset must not show up on wb
        c         = baseCtrl();
        c.regWen  = 1'b1;
        c.aluSrcB = srcBImm;
        c.aluOp   = aluPassB;
        rstN <= 1'b0;
        ctrl <= c;
        rs1  <= 5'd0;
        rs2  <= 5'd0;
        rd   <= 5'd5;
        pc   <= 64'h1000;
        imm  <= 64'h55;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        ctrl <= baseCtrl();
        rd   <= 5'd0;

        // every register reads zero after reset
        for (int r = 1; r < 32; r++) begin
            c        = baseCtrl();
            c.regWen = 1'b1;
            issue(c, 5'd0, 5'(r), 5'(r), 64'd0);
        end
        for (int r = 1; r < 32; r++) begin
            c         = baseCtrl();
            c.regWen  = 1'b1;
            c.aluSrcB = srcBImm;
            c.aluOp   = aluPassB;
            issue(c, 5'd0, 5'd0, 5'(r), rand64());
        end

        trapAndReturn();
        randomAluOps(400);
        storeThenLoads(40);
        branchesAndJumps(80);
        csrAccesses(60);
        repeat (3) trapAndReturn();

        issue(baseCtrl(), 5'd0, 5'd0, 5'd0, 64'd0);
        timeLeft = 10;
        do begin
            @(posedge clk);
            timeLeft--;
        end while (lastChecked != seq && timeLeft > 0);
        if (lastChecked != seq) begin
            $display("last instruction was not checked within 10 cycles");
            otherErrors++;
        end
        if (checks == 0) begin
            $display("no instruction was checked");
            otherErrors++;
        end

        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- source/exuTop.sv
`timescale 1ns/1ps

module exuTop #(
    parameter int unsigned memAddrBits     = 8,
    parameter logic [63:0] trapVectorReset = 64'h100
) (
    input  logic                clk,
    input  logic                rstN,
    input  exuCtrlPkg::exuCtrlT ctrl,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [4:0]          rd,
    input  logic [63:0]         pc,
    input  logic [63:0]         imm,
    output exuCtrlPkg::wbT      wb,
    output logic [63:0]         dnpc
);
    import exuCtrlPkg::*;

    operandsT    ops;
    logic [63:0] rs1Data;
    logic [63:0] aluResult;
    logic        aluZero;
    logic [63:0] loadData;
    logic [63:0] csrOld;
    logic [63:0] mepc;
    logic [63:0] mtvec;

    // register file inside, written from wb
    exuOperandSel operandSel_i (
        .clk     (clk),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .rs1     (rs1),
        .rs2     (rs2),
        .pc      (pc),
        .imm     (imm),
        .wb      (wb),
        .ops     (ops),
        .rs1Data (rs1Data)
    );

    exuAlu alu_i (
        .aluOp  (ctrl.aluOp),
        .a      (ops.aluA),
        .b      (ops.aluB),
        .result (aluResult),
        .zero   (aluZero)
    );

    // alu result doubles as the load/store address
    dataMem #(
        .memAddrBits (memAddrBits)
    ) dataMem_i (
        .clk       (clk),
        .rstN      (rstN),
        .memRead   (ctrl.memRead),
        .memWrite  (ctrl.memWrite),
        .memOp     (ctrl.memOp),
        .addr      (aluResult),
        .storeData (ops.storeData),
        .loadData  (loadData)
    );

    // csr number sits in the immediate field
    csrUnit #(
        .trapVectorReset (trapVectorReset)
    ) csrUnit_i (
        .clk    (clk),
        .rstN   (rstN),
        .csrOp  (ctrl.csrOp),
        .csrId  (imm[11:0]),
        .csrIn  (ops.csrIn),
        .pc     (pc),
        .csrOld (csrOld),
        .mepc   (mepc),
        .mtvec  (mtvec)
    );

    exuCommit commit_i (
        .ctrl     (ctrl),
        .rd       (rd),
        .pc       (pc),
        .imm      (imm),
        .rs1Data  (rs1Data),
        .result   (aluResult),
        .loadData (loadData),
        .csrOld   (csrOld),
        .mepc     (mepc),
        .mtvec    (mtvec),
        .zero     (aluZero),
        .rstN     (rstN),
        .wb       (wb),
        .dnpc     (dnpc)
    );

endmodule

//--- source/exuCommit.sv
`timescale 1ns/1ps

module exuCommit (
    input  exuCtrlPkg::exuCtrlT ctrl,
    input  logic [4:0]          rd,
    input  logic [63:0]         pc,
    input  logic [63:0]         imm,
    input  logic [63:0]         rs1Data,
    input  logic [63:0]         result,
    input  logic [63:0]         loadData,
    input  logic [63:0]         csrOld,
    input  logic [63:0]         mepc,
    input  logic [63:0]         mtvec,
    input  logic                zero,
    input  logic                rstN,
    output exuCtrlPkg::wbT      wb,
    output logic [63:0]         dnpc
);
    import rvIsaPkg::*;
    import exuCtrlPkg::*;

    logic        baseRs1;
    logic        addImm;
    logic [63:0] target;
    logic [63:0] nextPc;

    always_comb begin
        case (ctrl.wbSel)
            wbLoad:  wb.data = loadData;
            wbCsr:   wb.data = csrOld;
            default: wb.data = result;
        endcase
        wb.rd    = rd;
        wb.valid = ctrl.regWen && rstN && (rd != 5'd0);
    end

    // base is pc or rs1, offset is imm when taken, else 4
    always_comb begin
        baseRs1 = 1'b0;
        addImm  = 1'b0;
        case (ctrl.branch)
            brJal: addImm = 1'b1;
            brJalr: begin
                baseRs1 = 1'b1;
                addImm  = 1'b1;
            end
            brBeq: addImm = zero;
            brBne: addImm = !zero;
            // alu ran slt or sltu
            brBlt: addImm = result[0];
            brBge: addImm = zero || !result[0];
            default: ;
        endcase
    end

    assign target = (baseRs1 ? rs1Data : pc) + (addImm ? imm : 64'd4);

    always_comb begin
        case (ctrl.csrOp)
            csrEcall: nextPc = mtvec;
            csrMret:  nextPc = mepc;
            default:  nextPc = target;
        endcase
    end

    // jalr clears bit 0, applied to every target
    assign dnpc = {nextPc[63:1], 1'b0};

endmodule

//--- source/dataMem.sv
`timescale 1ns/1ps

module dataMem #(
    parameter int unsigned memAddrBits = 8
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            memRead,
    input  logic            memWrite,
    input  rvIsaPkg::memOpE memOp,
    input  logic [63:0]     addr,
    input  logic [63:0]     storeData,
    output logic [63:0]     loadData
);
    import rvIsaPkg::*;

    localparam int unsigned depth = 2 ** memAddrBits;

    logic [63:0]            mem [depth];
    logic [memAddrBits-1:0] index;
    logic [2:0]             offset;
    logic [7:0]             byteEn;
    logic [2:0]             alignMask;
    logic [63:0]            laneData;
    logic [63:0]            rawWord;

    // upper address bits are dropped, so accesses wrap
    assign index    = addr[memAddrBits+2:3];
    assign offset   = addr[2:0];
    assign laneData = storeData << {offset, 3'b000};
    assign rawWord  = mem[index] >> {offset, 3'b000};

    always_comb begin
        case (memOp[1:0])
            2'b00: begin
                byteEn    = 8'h01 << offset;
                alignMask = 3'b000;
            end
            2'b01: begin
                byteEn    = 8'h03 << offset;
                alignMask = 3'b001;
            end
            2'b10: begin
                byteEn    = 8'h0f << offset;
                alignMask = 3'b011;
            end
            default: begin
                byteEn    = 8'hff;
                alignMask = 3'b111;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= 64'd0;
            end
        end else if (memWrite) begin
            for (int n = 0; n < 8; n++) begin
                if (byteEn[n]) begin
                    mem[index][8*n +: 8] <= laneData[8*n +: 8];
                end
            end
        end
    end

    always_comb begin
        if (!memRead) begin
            loadData = 64'd0;
        end else begin
            case (memOp)
                memLb:   loadData = {{56{rawWord[7]}}, rawWord[7:0]};
                memLh:   loadData = {{48{rawWord[15]}}, rawWord[15:0]};
                memLw:   loadData = {{32{rawWord[31]}}, rawWord[31:0]};
                memLbu:  loadData = {56'd0, rawWord[7:0]};
                memLhu:  loadData = {48'd0, rawWord[15:0]};
                memLwu:  loadData = {32'd0, rawWord[31:0]};
                default: loadData = rawWord;
            endcase
        end
    end

    // no misaligned support
    alignedAccess: assert property (@(posedge clk) disable iff (!rstN)
        (memRead || memWrite) |-> ((offset & alignMask) == 3'd0))
        else $error("misaligned access at %h", addr);

endmodule

//--- source/csrUnit.sv
`timescale 1ns/1ps

module csrUnit #(
    parameter logic [63:0] trapVectorReset = 64'h100
) (
    input  logic            clk,
    input  logic            rstN,
    input  rvIsaPkg::csrOpE csrOp,
    input  logic [11:0]     csrId,
    input  logic [63:0]     csrIn,
    input  logic [63:0]     pc,
    output logic [63:0]     csrOld,
    output logic [63:0]     mepc,
    output logic [63:0]     mtvec
);
    import rvIsaPkg::*;

    logic [63:0] mstatus;
    logic [63:0] mscratch;
    logic [63:0] mcause;
    logic [63:0] csrNew;
    logic        csrWen;
    logic        knownId;

    always_comb begin
        knownId = 1'b1;
        case (csrId)
            csrMstatus:  csrOld = mstatus;
            csrMtvec:    csrOld = mtvec;
            csrMscratch: csrOld = mscratch;
            csrMepc:     csrOld = mepc;
            csrMcause:   csrOld = mcause;
            default: begin
                csrOld  = 64'd0;
                knownId = 1'b0;
            end
        endcase
    end

    assign csrWen = (csrOp == csrWrite) || (csrOp == csrSet) || (csrOp == csrClear);

    // read-modify-write value
    always_comb begin
        case (csrOp)
            csrSet:   csrNew = csrOld | csrIn;
            csrClear: csrNew = csrOld & ~csrIn;
            default:  csrNew = csrIn;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mstatus  <= 64'd0;
            mtvec    <= trapVectorReset;
            mscratch <= 64'd0;
            mepc     <= 64'd0;
            mcause   <= 64'd0;
        end else if (csrOp == csrEcall) begin
            // trap entry, the jump to mtvec is resolved in commit
            mepc   <= pc;
            mcause <= causeEcallM;
        end else if (csrWen) begin
            case (csrId)
                csrMstatus:  mstatus  <= csrNew;
                csrMtvec:    mtvec    <= csrNew;
                csrMscratch: mscratch <= csrNew;
                csrMepc:     mepc     <= csrNew;
                csrMcause:   mcause   <= csrNew;
                default: ;
            endcase
        end
    end

    // decoder only issues csr writes to implemented registers
    knownIdOnWrite: assert property (@(posedge clk) disable iff (!rstN)
        csrWen |-> knownId)
        else $error("csr write to unknown id %h", csrId);

endmodule

//--- source/exuAlu.sv
`timescale 1ns/1ps

module exuAlu (
    input  rvIsaPkg::aluOpE aluOp,
    input  logic [63:0]     a,
    input  logic [63:0]     b,
    output logic [63:0]     result,
    output logic            zero
);
    import rvIsaPkg::*;

    logic [63:0] mulRes;
    logic [31:0] wordRes;

    // low half only for mul and mulw
    assign mulRes = a * b;

    // word forms are sign-extended below
    always_comb begin
        wordRes = 32'd0;
        case (aluOp)
            aluAddw: wordRes = a[31:0] + b[31:0];
            aluSubw: wordRes = a[31:0] - b[31:0];
            aluSllw: wordRes = a[31:0] << b[4:0];
            aluSrlw: wordRes = a[31:0] >> b[4:0];
            aluSraw: wordRes = $signed(a[31:0]) >>> b[4:0];
            aluMulw: wordRes = mulRes[31:0];
            default: ;
        endcase
    end

    always_comb begin
        case (aluOp)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluSll:   result = a << b[5:0];
            aluSlt:   result = {63'd0, $signed(a) < $signed(b)};
            aluSltu:  result = {63'd0, a < b};
            aluXor:   result = a ^ b;
            aluSrl:   result = a >> b[5:0];
            aluSra:   result = $signed(a) >>> b[5:0];
            aluOr:    result = a | b;
            aluAnd:   result = a & b;
            aluMul:   result = mulRes;
            // lui
            aluPassB: result = b;
            default:  result = {{32{wordRes[31]}}, wordRes};
        endcase
    end

    // branches read this together with result bit 0
    assign zero = (result == 64'd0);

endmodule

//--- source/exuOperandSel.sv
`timescale 1ns/1ps

module exuOperandSel (
    input  logic                 clk,
    input  logic                 rstN,
    input  exuCtrlPkg::exuCtrlT  ctrl,
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    input  logic [63:0]          pc,
    input  logic [63:0]          imm,
    input  exuCtrlPkg::wbT       wb,
    output exuCtrlPkg::operandsT ops,
    output logic [63:0]          rs1Data
);
    import exuCtrlPkg::*;

    logic [63:0] rs2Data;

    // writeback from the commit side lands at the end of the cycle
    gprFile gprFile_i (
        .clk    (clk),
        .rstN   (rstN),
        .raddrA (rs1),
        .raddrB (rs2),
        .rdataA (rs1Data),
        .rdataB (rs2Data),
        .wen    (wb.valid),
        .waddr  (wb.rd),
        .wdata  (wb.data)
    );

    always_comb begin
        ops.aluA = (ctrl.aluSrcA == srcAPc) ? pc : rs1Data;

        case (ctrl.aluSrcB)
            srcBImm:  ops.aluB = imm;
            // link address for jal and jalr
            srcBFour: ops.aluB = 64'd4;
            default:  ops.aluB = rs2Data;
        endcase

        ops.storeData = rs2Data;

        // csrrwi and friends take the rs1 field as a 5-bit constant
        if (ctrl.csrSrcImm) begin
            ops.csrIn = {59'd0, rs1};
        end else begin
            ops.csrIn = rs1Data;
        end
    end

endmodule

//--- source/gprFile.sv
`timescale 1ns/1ps

module gprFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  raddrA,
    input  logic [4:0]  raddrB,
    output logic [63:0] rdataA,
    output logic [63:0] rdataB,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [63:0] wdata
);
    // x0 has no storage
    logic [63:0] regs [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 64'd0;
            end
        end else if (wen && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdataA = (raddrA == 5'd0) ? 64'd0 : regs[raddrA];
    assign rdataB = (raddrB == 5'd0) ? 64'd0 : regs[raddrB];

    // a written value is seen on port a in the next cycle
    readAfterWrite: assert property (@(posedge clk) disable iff (!rstN)
        (wen && (waddr != 5'd0)) |=> ((raddrA != $past(waddr)) || (rdataA == $past(wdata))))
        else $error("register read after write returned stale data");

endmodule

//--- source/exuCtrlPkg.sv
package exuCtrlPkg;

    // operand a source
    typedef enum logic {
        srcAPc  = 1'b0,
        srcARs1 = 1'b1
    } srcAE;

    typedef enum logic [1:0] {
        srcBRs2  = 2'b00,
        srcBImm  = 2'b01,
        srcBFour = 2'b10
    } srcBE;

    typedef enum logic [1:0] {
        wbAlu  = 2'b00,
        wbLoad = 2'b01,
        wbCsr  = 2'b10
    } wbSelE;

    // decoded control for one instruction
    typedef struct packed {
        logic             regWen;
        srcAE             aluSrcA;
        srcBE             aluSrcB;
        rvIsaPkg::aluOpE  aluOp;
        rvIsaPkg::branchE branch;
        logic             memRead;
        logic             memWrite;
        rvIsaPkg::memOpE  memOp;
        rvIsaPkg::csrOpE  csrOp;
        logic             csrSrcImm;
        wbSelE            wbSel;
    } exuCtrlT;

    typedef struct packed {
        logic [63:0] aluA;
        logic [63:0] aluB;
        logic [63:0] storeData;
        logic [63:0] csrIn;
    } operandsT;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [63:0] data;
    } wbT;

endpackage

//--- source/rvIsaPkg.sv
package rvIsaPkg;

    // alu operations, the w forms work on the low word
    typedef enum logic [4:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluMul,
        aluAddw,
        aluSubw,
        aluSllw,
        aluSrlw,
        aluSraw,
        aluMulw,
        aluPassB
    } aluOpE;

    // blt/bltu and bge/bgeu share codes, the alu picks slt or sltu
    typedef enum logic [2:0] {
        brNone = 3'b000,
        brJal  = 3'b001,
        brJalr = 3'b010,
        brBeq  = 3'b100,
        brBne  = 3'b101,
        brBlt  = 3'b110,
        brBge  = 3'b111
    } branchE;

    // low two bits give the access width, stores use only those
    typedef enum logic [2:0] {
        memLb  = 3'b000,
        memLh  = 3'b001,
        memLw  = 3'b010,
        memLd  = 3'b011,
        memLbu = 3'b100,
        memLhu = 3'b101,
        memLwu = 3'b110
    } memOpE;

    typedef enum logic [2:0] {
        csrNone,
        csrWrite,
        csrSet,
        csrClear,
        csrEcall,
        csrMret
    } csrOpE;

    localparam logic [11:0] csrMstatus  = 12'h300;
    localparam logic [11:0] csrMtvec    = 12'h305;
    localparam logic [11:0] csrMscratch = 12'h340;
    localparam logic [11:0] csrMepc     = 12'h341;
    localparam logic [11:0] csrMcause   = 12'h342;

    // environment call from machine mode
    localparam logic [63:0] causeEcallM = 64'd11;

endpackage
